/* source/vec_pkg.sv */
`default_nettype none

package vec_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NR_LANES       = 2;
  localparam int unsigned ELEN           = 32;
  localparam int unsigned ELEMS_PER_VREG = 8;
  // Elements interleaved across lanes by index bit 0
  localparam int unsigned ELEMS_PER_LANE = ELEMS_PER_VREG / NR_LANES;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned VREG_IDX_W     = 3;
  localparam int unsigned SLOT_IDX_W     = 2;
  localparam int unsigned WB_ADR_W       = 8;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Word addresses on the host bus
  localparam logic [WB_ADR_W-1:0] ADR_CMD       = 8'h00;
  localparam logic [WB_ADR_W-1:0] ADR_STATUS    = 8'h01;
  localparam logic [WB_ADR_W-1:0] ADR_SCALAR    = 8'h02;
  // Element window: bits 5..3 register, 2..1 slot, 0 lane
  localparam logic [WB_ADR_W-1:0] ADR_ELEM_BASE = 8'h80;

  // Command word fields
  localparam int unsigned CMD_OP_LSB  = 0;
  localparam int unsigned CMD_VD_LSB  = 4;
  localparam int unsigned CMD_VS1_LSB = 8;
  localparam int unsigned CMD_VS2_LSB = 12;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ELEN-1:0] elem_t;

  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,
    OP_VSUB    = 3'd1,
    OP_VAND    = 3'd2,
    OP_VXOR    = 3'd3,
    OP_VREDSUM = 3'd4
  } vec_op_e;

  // Only one instruction in flight at a time
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_EXEC   = 2'd1,
    ST_REDUCE = 2'd2
  } disp_state_e;

endpackage : vec_pkg

`default_nettype wire

/* source/vec_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // Wishbone classic slave
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [vec_pkg::WB_ADR_W-1:0]           wb_adr_i,
  input  vec_pkg::elem_t                         wb_dat_i,
  output vec_pkg::elem_t                         wb_dat_o,
  output logic                                   wb_ack_o,
  // Command to the lanes
  output logic                                   start_o,
  output vec_pkg::vec_op_e                       op_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]         vd_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]         vs1_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]         vs2_o,
  // Host element access
  output logic [vec_pkg::NR_LANES-1:0]           elem_we_o,
  output logic [vec_pkg::VREG_IDX_W-1:0]         elem_reg_o,
  output logic [vec_pkg::SLOT_IDX_W-1:0]         elem_slot_o,
  output vec_pkg::elem_t                         elem_wdata_o,
  input  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0] elem_rdata_i,
  // Completion
  input  logic [vec_pkg::NR_LANES-1:0]           lane_done_i,
  input  vec_pkg::elem_t                         scalar_i,
  input  logic                                   scalar_valid_i
);

  import vec_pkg::*;

  disp_state_e                 state_q, state_d;
  logic                        req, busy, can_ack, cmd_fire;
  logic                        sel_cmd, sel_status, sel_scalar, sel_elem;
  logic                        lane_sel;
  logic [$bits(vec_op_e)-1:0]  cmd_op_raw;
  logic                        op_known;
  logic                        ack_q, start_q;
  vec_op_e                     op_q;
  logic [VREG_IDX_W-1:0]       vd_q, vs1_q, vs2_q;
  elem_t                       rdata, dat_q;

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  // Masked while ack is out so the held strobe is not taken twice
  assign req        = wb_cyc_i & wb_stb_i & ~ack_q;
  assign sel_cmd    = wb_adr_i == ADR_CMD;
  assign sel_status = wb_adr_i == ADR_STATUS;
  assign sel_scalar = wb_adr_i == ADR_SCALAR;
  assign sel_elem   = wb_adr_i[WB_ADR_W-1:VREG_IDX_W+SLOT_IDX_W+1] ==
                      ADR_ELEM_BASE[WB_ADR_W-1:VREG_IDX_W+SLOT_IDX_W+1];
  assign lane_sel   = wb_adr_i[0];

  assign busy = (state_q != ST_IDLE) | start_q;

  // Commands and element accesses wait for idle
  assign can_ack = req & ~((sel_cmd | sel_elem) & busy);

  assign cmd_op_raw = wb_dat_i[CMD_OP_LSB +: $bits(vec_op_e)];
  assign op_known   = cmd_op_raw inside {OP_VADD, OP_VSUB, OP_VAND, OP_VXOR, OP_VREDSUM};
  assign cmd_fire   = can_ack & wb_we_i & sel_cmd & op_known;

  // Element port fields taken straight from the window address
  assign elem_reg_o   = wb_adr_i[VREG_IDX_W+SLOT_IDX_W:SLOT_IDX_W+1];
  assign elem_slot_o  = wb_adr_i[SLOT_IDX_W:1];
  assign elem_wdata_o = wb_dat_i;

  always_comb begin
    elem_we_o = '0;
    if (can_ack && wb_we_i && sel_elem) begin
      elem_we_o[lane_sel] = 1'b1;
    end
  end

  // Unmapped reads give zero
  always_comb begin
    rdata = '0;
    if (sel_status) begin
      rdata[0] = busy;
    end else if (sel_scalar) begin
      rdata = scalar_i;
    end else if (sel_elem) begin
      rdata = elem_rdata_i[lane_sel];
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_ack && !wb_we_i) begin
      dat_q <= rdata;
    end
  end

  //////////////////////////////////////////////////
  // Command latch and FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      op_q    <= OP_VADD;
      vd_q    <= '0;
      vs1_q   <= '0;
      vs2_q   <= '0;
      state_q <= ST_IDLE;
    end else begin
      ack_q   <= can_ack;
      start_q <= cmd_fire;
      state_q <= state_d;
      if (cmd_fire) begin
        op_q  <= vec_op_e'(cmd_op_raw);
        vd_q  <= wb_dat_i[CMD_VD_LSB +: VREG_IDX_W];
        vs1_q <= wb_dat_i[CMD_VS1_LSB +: VREG_IDX_W];
        vs2_q <= wb_dat_i[CMD_VS2_LSB +: VREG_IDX_W];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_q) state_d = ST_EXEC;
      end
      ST_EXEC: begin
        // Lanes run in lockstep so done arrives together
        if (&lane_done_i) state_d = (op_q == OP_VREDSUM) ? ST_REDUCE : ST_IDLE;
      end
      ST_REDUCE: begin
        if (scalar_valid_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;
  assign start_o  = start_q;
  assign op_o     = op_q;
  assign vd_o     = vd_q;
  assign vs1_o    = vs1_q;
  assign vs2_o    = vs2_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_ack_single : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack held for two cycles");

  a_start_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_o |-> state_q == ST_IDLE)
    else $error("start outside idle");

endmodule : vec_dispatcher

`default_nettype wire

/* source/vec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Command, held stable by the dispatcher during execution
  input  logic                           start_i,
  input  vec_pkg::vec_op_e               op_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0] vd_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0] vs1_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0] vs2_i,
  // Host element access
  input  logic                           elem_we_i,
  input  logic [vec_pkg::VREG_IDX_W-1:0] elem_reg_i,
  input  logic [vec_pkg::SLOT_IDX_W-1:0] elem_slot_i,
  input  vec_pkg::elem_t                 elem_wdata_i,
  output vec_pkg::elem_t                 elem_rdata_o,
  // Results
  output logic                           done_o,
  output vec_pkg::elem_t                 partial_sum_o,
  output logic                           partial_valid_o
);

  import vec_pkg::*;

  // Register slice: this lane's elements of every vector register
  elem_t                 vrf_q [NR_VREGS][ELEMS_PER_LANE];

  logic                  exec_q;
  logic [SLOT_IDX_W-1:0] slot_q;
  logic                  last_slot;
  logic                  is_red;
  elem_t                 opa, opb;
  elem_t                 alu_res;
  elem_t                 acc_q, acc_sum;

  //////////////////////////////////////////////////
  // Operands and ALU
  //////////////////////////////////////////////////

  assign opa       = vrf_q[vs1_i][slot_q];
  assign opb       = vrf_q[vs2_i][slot_q];
  assign last_slot = slot_q == SLOT_IDX_W'(ELEMS_PER_LANE - 1);
  assign is_red    = op_i == OP_VREDSUM;

  always_comb begin
    alu_res = '0;
    case (op_i)
      OP_VADD: alu_res = opb + opa;
      // RVV operand order, vd = vs2 - vs1
      OP_VSUB: alu_res = opb - opa;
      OP_VAND: alu_res = opb & opa;
      OP_VXOR: alu_res = opb ^ opa;
      default: alu_res = '0;
    endcase
  end

  // Running sum of vs2, wraps at ELEN bits
  assign acc_sum = acc_q + opb;

  //////////////////////////////////////////////////
  // Slot sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exec_q <= 1'b0;
      slot_q <= '0;
      acc_q  <= '0;
    end else if (start_i) begin
      exec_q <= 1'b1;
      slot_q <= '0;
      acc_q  <= '0;
    end else if (exec_q) begin
      slot_q <= slot_q + 1'b1;
      acc_q  <= acc_sum;
      if (last_slot) begin
        exec_q <= 1'b0;
      end
    end
  end

  // One write port, host access or ALU result
  always_ff @(posedge clk_i) begin
    if (elem_we_i) begin
      vrf_q[elem_reg_i][elem_slot_i] <= elem_wdata_i;
    end else if (exec_q && !is_red) begin
      vrf_q[vd_i][slot_q] <= alu_res;
    end
  end

  assign elem_rdata_o = vrf_q[elem_reg_i][elem_slot_i];

  // High during the final slot, together with its write
  assign done_o          = exec_q & last_slot;
  assign partial_valid_o = done_o & is_red;
  assign partial_sum_o   = acc_sum;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_no_host_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exec_q |-> !elem_we_i)
    else $error("host element write during execution");

endmodule : vec_lane

`default_nettype wire

/* source/vec_reduction.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_reduction (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0] partial_sum_i,
  input  logic [vec_pkg::NR_LANES-1:0]           partial_valid_i,
  output vec_pkg::elem_t                         scalar_o,
  output logic                                   scalar_valid_o
);

  import vec_pkg::*;

  elem_t lane_sum;
  elem_t scalar_q;
  logic  all_valid;
  logic  valid_q;

  //////////////////////////////////////////////////
  // Cross-lane combine
  //////////////////////////////////////////////////

  always_comb begin
    lane_sum = '0;
    for (int unsigned l = 0; l < NR_LANES; l++) begin
      lane_sum = lane_sum + partial_sum_i[l];
    end
  end

  assign all_valid = &partial_valid_i;

  // Scalar result held until the next reduction
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scalar_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= all_valid;
      if (all_valid) begin
        scalar_q <= lane_sum;
      end
    end
  end

  assign scalar_o       = scalar_q;
  assign scalar_valid_o = valid_q;

  // Lanes finish in lockstep
  a_lanes_aligned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|partial_valid_i) |-> all_valid)
    else $error("partial sums arrived out of step");

endmodule : vec_reduction

`default_nettype wire

/* source/vec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_unit (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Wishbone classic slave
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [vec_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  vec_pkg::elem_t               wb_dat_i,
  output vec_pkg::elem_t               wb_dat_o,
  output logic                         wb_ack_o
);

  import vec_pkg::*;

  // Dispatcher to lanes
  logic                          start;
  vec_op_e                       op;
  logic [VREG_IDX_W-1:0]         vd, vs1, vs2;
  logic [NR_LANES-1:0]           elem_we;
  logic [VREG_IDX_W-1:0]         elem_reg;
  logic [SLOT_IDX_W-1:0]         elem_slot;
  elem_t                         elem_wdata;
  // Lanes back to dispatcher and combiner
  elem_t [NR_LANES-1:0]          elem_rdata;
  logic  [NR_LANES-1:0]          lane_done;
  elem_t [NR_LANES-1:0]          partial_sum;
  logic  [NR_LANES-1:0]          partial_valid;
  // Combiner to dispatcher
  elem_t                         scalar;
  logic                          scalar_valid;

  vec_dispatcher dispatcher_i (
    .clk_i          (clk_i       ),
    .arst_n_i       (arst_n_i    ),
    .wb_cyc_i       (wb_cyc_i    ),
    .wb_stb_i       (wb_stb_i    ),
    .wb_we_i        (wb_we_i     ),
    .wb_adr_i       (wb_adr_i    ),
    .wb_dat_i       (wb_dat_i    ),
    .wb_dat_o       (wb_dat_o    ),
    .wb_ack_o       (wb_ack_o    ),
    .start_o        (start       ),
    .op_o           (op          ),
    .vd_o           (vd          ),
    .vs1_o          (vs1         ),
    .vs2_o          (vs2         ),
    .elem_we_o      (elem_we     ),
    .elem_reg_o     (elem_reg    ),
    .elem_slot_o    (elem_slot   ),
    .elem_wdata_o   (elem_wdata  ),
    .elem_rdata_i   (elem_rdata  ),
    .lane_done_i    (lane_done   ),
    .scalar_i       (scalar      ),
    .scalar_valid_i (scalar_valid)
  );

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane lane_i (
      .clk_i           (clk_i           ),
      .arst_n_i        (arst_n_i        ),
      .start_i         (start           ),
      .op_i            (op              ),
      .vd_i            (vd              ),
      .vs1_i           (vs1             ),
      .vs2_i           (vs2             ),
      .elem_we_i       (elem_we[l]      ),
      .elem_reg_i      (elem_reg        ),
      .elem_slot_i     (elem_slot       ),
      .elem_wdata_i    (elem_wdata      ),
      .elem_rdata_o    (elem_rdata[l]   ),
      .done_o          (lane_done[l]    ),
      .partial_sum_o   (partial_sum[l]  ),
      .partial_valid_o (partial_valid[l])
    );
  end : gen_lanes

  vec_reduction reduction_i (
    .clk_i           (clk_i        ),
    .arst_n_i        (arst_n_i     ),
    .partial_sum_i   (partial_sum  ),
    .partial_valid_i (partial_valid),
    .scalar_o        (scalar       ),
    .scalar_valid_o  (scalar_valid )
  );

endmodule : vec_unit

`default_nettype wire

/* include/tb_wb_bus.svh */
`ifndef TB_WB_BUS_SVH
`define TB_WB_BUS_SVH

// Wishbone classic master for the testbench module
// Requests change on the falling edge and ack is sampled there too

// Ack is a one-cycle pulse and is low again by the next request
task automatic check_ack_low();
  assert (!wb_ack_o)
    else begin
      errors++;
      $display("Error at time %0t: ack still high when a new transfer starts", $time);
    end
endtask

// Block until the slave acks with no cycle limit of its own
task automatic wait_for_ack();
  @(negedge clk_i);
  while (!wb_ack_o) begin
    @(negedge clk_i);
  end
endtask

// Drop the strobe in the same half cycle that saw ack
task automatic release_bus();
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
  wb_adr_i = '0;
  wb_dat_i = '0;
endtask

task automatic write_word(input logic [WB_ADR_W-1:0] adr, input elem_t dat);
  @(negedge clk_i);
  check_ack_low();
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = 1'b1;
  wb_adr_i = adr;
  wb_dat_i = dat;
  wait_for_ack();
  release_bus();
  bus_ops++;
endtask

task automatic read_word(input logic [WB_ADR_W-1:0] adr, output elem_t dat);
  @(negedge clk_i);
  check_ack_low();
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = 1'b0;
  wb_adr_i = adr;
  wb_dat_i = '0;
  wait_for_ack();
  // Read data is registered together with ack
  dat = wb_dat_o;
  release_bus();
  bus_ops++;
endtask

`endif

/* verif/tb_vec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vec_unit;

  import vec_pkg::*;

  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned ELEM_IDX_W    = 3;
  localparam int unsigned NR_EW_CMDS    = 24;
  localparam int unsigned NR_RED_CMDS   = 6;
  localparam int unsigned NR_BP_ROUNDS  = 4;
  localparam int unsigned NR_BAD_OPS    = 3;
  localparam int unsigned NR_UNMAPPED   = 8;
  localparam int unsigned POLL_BOUND    = 8;
  localparam int unsigned VRF_ELEMS     = NR_VREGS * ELEMS_PER_VREG;
  localparam int unsigned CYCLES_PER_OP = 20;
  // Bus operations over the whole run, status polling bounded per command
  localparam int unsigned BUS_OPS = 2 + 2 * VRF_ELEMS
    + NR_EW_CMDS * (1 + POLL_BOUND + ELEMS_PER_VREG)
    + NR_RED_CMDS * (2 + POLL_BOUND) + VRF_ELEMS
    + NR_BP_ROUNDS * (4 + 2 * POLL_BOUND + ELEMS_PER_VREG)
    + NR_BAD_OPS * 3 + 4 + VRF_ELEMS + NR_UNMAPPED;
  localparam int unsigned TIMEOUT_NS =
    (BUS_OPS * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD;

  logic                clk_i;
  logic                arst_n_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [WB_ADR_W-1:0] wb_adr_i;
  elem_t               wb_dat_i;
  elem_t               wb_dat_o;
  logic                wb_ack_o;

  // Reference model of the register file and the scalar result
  elem_t       model_vrf [NR_VREGS][ELEMS_PER_VREG];
  elem_t       model_scalar;
  int          seed;
  int unsigned errors;
  int unsigned checks;
  int unsigned bus_ops;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  vec_unit vec_unit_i (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i ),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  `include "tb_wb_bus.svh"

  //////////////////////////////////////////////////
  // Model and helpers
  //////////////////////////////////////////////////

  // Element window: register in 5..3, slot in 2..1, lane in 0
  function automatic logic [WB_ADR_W-1:0] elem_addr(input logic [VREG_IDX_W-1:0] vreg,
                                                    input logic [ELEM_IDX_W-1:0] idx);
    logic [WB_ADR_W-1:0] adr;
    adr      = ADR_ELEM_BASE;
    adr[5:3] = vreg;
    adr[2:1] = idx[2:1];
    adr[0]   = idx[0];
    return adr;
  endfunction

  function automatic elem_t cmd_word(input logic [2:0] op, input logic [VREG_IDX_W-1:0] vd,
                                     input logic [VREG_IDX_W-1:0] vs1,
                                     input logic [VREG_IDX_W-1:0] vs2);
    elem_t w;
    w = '0;
    w[CMD_OP_LSB +: 3]           = op;
    w[CMD_VD_LSB +: VREG_IDX_W]  = vd;
    w[CMD_VS1_LSB +: VREG_IDX_W] = vs1;
    w[CMD_VS2_LSB +: VREG_IDX_W] = vs2;
    return w;
  endfunction

  // a from vs1, b from vs2, subtract gives vs2 - vs1
  function automatic elem_t alu_model(input logic [2:0] op, input elem_t a, input elem_t b);
    elem_t r;
    case (op)
      OP_VADD: r = b + a;
      OP_VSUB: r = b - a;
      OP_VAND: r = b & a;
      OP_VXOR: r = b ^ a;
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic apply_model(input logic [2:0] op, input logic [VREG_IDX_W-1:0] vd,
                             input logic [VREG_IDX_W-1:0] vs1,
                             input logic [VREG_IDX_W-1:0] vs2);
    elem_t                 sum;
    logic [ELEM_IDX_W-1:0] idx;
    sum = '0;
    for (int unsigned e = 0; e < ELEMS_PER_VREG; e++) begin
      idx = ELEM_IDX_W'(e);
      if (op == OP_VREDSUM) begin
        sum = sum + model_vrf[vs2][idx];
      end else begin
        model_vrf[vd][idx] = alu_model(op, model_vrf[vs1][idx], model_vrf[vs2][idx]);
      end
    end
    if (op == OP_VREDSUM) begin
      model_scalar = sum;
    end
  endtask

  task automatic expect_equal(input elem_t got, input elem_t exp, input string what);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("Error at time %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
  endtask

  task automatic verify_vreg(input logic [VREG_IDX_W-1:0] vreg);
    elem_t                 got;
    logic [ELEM_IDX_W-1:0] idx;
    for (int unsigned e = 0; e < ELEMS_PER_VREG; e++) begin
      idx = ELEM_IDX_W'(e);
      read_word(elem_addr(vreg, idx), got);
      expect_equal(got, model_vrf[vreg][idx], $sformatf("v%0d[%0d]", vreg, e));
    end
  endtask

  task automatic sweep_vrf();
    for (int unsigned r = 0; r < NR_VREGS; r++) begin
      verify_vreg(VREG_IDX_W'(r));
    end
  endtask

  task automatic issue_op(input logic [2:0] op, input logic [VREG_IDX_W-1:0] vd,
                          input logic [VREG_IDX_W-1:0] vs1,
                          input logic [VREG_IDX_W-1:0] vs2);
    write_word(ADR_CMD, cmd_word(op, vd, vs1, vs2));
    apply_model(op, vd, vs1, vs2);
  endtask

  // Busy must show on the first poll after the command ack
  task automatic await_completion();
    elem_t status;
    read_word(ADR_STATUS, status);
    expect_equal(status, 32'd1, "status after command");
    while (status[0]) begin
      read_word(ADR_STATUS, status);
    end
    expect_equal(status, '0, "status at completion");
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    elem_t                 rdata;
    logic [31:0]           rnd;
    logic [2:0]            op;
    logic [VREG_IDX_W-1:0] vd, vs1, vs2, vd2, vr;
    logic [ELEM_IDX_W-1:0] idx;
    logic [WB_ADR_W-1:0]   adr;

    seed     = 32'h445e;
    errors   = 0;
    checks   = 0;
    bus_ops  = 0;
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Reset state
    read_word(ADR_STATUS, rdata);
    expect_equal(rdata, '0, "status after reset");
    read_word(ADR_SCALAR, rdata);
    expect_equal(rdata, '0, "scalar after reset");
    model_scalar = '0;

    // Fill every element and read it all back
    for (int unsigned r = 0; r < NR_VREGS; r++) begin
      for (int unsigned e = 0; e < ELEMS_PER_VREG; e++) begin
        vr  = VREG_IDX_W'(r);
        idx = ELEM_IDX_W'(e);
        rnd = $random(seed);
        model_vrf[vr][idx] = rnd;
        write_word(elem_addr(vr, idx), rnd);
      end
    end
    sweep_vrf();

    // Element-wise operations
    for (int unsigned n = 0; n < NR_EW_CMDS; n++) begin
      rnd = $random(seed);
      op  = {1'b0, rnd[1:0]};
      vd  = rnd[6:4];
      vs1 = rnd[10:8];
      vs2 = rnd[14:12];
      // Destination aliased onto a source
      if (n % 4 == 0) begin
        vd = vs1;
      end else if (n % 4 == 1) begin
        vd = vs2;
      end
      issue_op(op, vd, vs1, vs2);
      await_completion();
      verify_vreg(vd);
    end

    // Sum reductions
    for (int unsigned n = 0; n < NR_RED_CMDS; n++) begin
      rnd = $random(seed);
      issue_op(OP_VREDSUM, rnd[6:4], rnd[10:8], rnd[14:12]);
      await_completion();
      read_word(ADR_SCALAR, rdata);
      expect_equal(rdata, model_scalar, "scalar after reduction");
    end
    sweep_vrf();

    // Back to back requests held off by the busy unit
    for (int unsigned n = 0; n < NR_BP_ROUNDS; n++) begin
      rnd = $random(seed);
      vd  = rnd[6:4];
      vs1 = rnd[10:8];
      vs2 = rnd[14:12];
      if (n % 2 == 1) begin
        op = OP_VREDSUM;
      end else begin
        op = {1'b0, rnd[1:0]};
      end
      issue_op(op, vd, vs1, vs2);
      // Chained on the first result
      vd2 = rnd[22:20];
      issue_op({1'b0, rnd[17:16]}, vd2, vd, vs2);
      idx = rnd[26:24];
      rnd = $random(seed);
      model_vrf[vd2][idx] = rnd;
      write_word(elem_addr(vd2, idx), rnd);
      verify_vreg(vd2);
      read_word(ADR_SCALAR, rdata);
      expect_equal(rdata, model_scalar, "scalar after chained commands");
    end

    // Unknown opcodes
    for (int unsigned n = 0; n < NR_BAD_OPS; n++) begin
      rnd = $random(seed);
      op  = 3'(5 + n);
      write_word(ADR_CMD, cmd_word(op, rnd[6:4], rnd[10:8], rnd[14:12]));
      read_word(ADR_STATUS, rdata);
      expect_equal(rdata, '0, "status after unknown opcode");
      read_word(ADR_SCALAR, rdata);
      expect_equal(rdata, model_scalar, "scalar after unknown opcode");
    end

    // Writes to read-only and unmapped words
    write_word(ADR_STATUS, 32'hffff_ffff);
    write_word(ADR_SCALAR, 32'h1234_5678);
    write_word(8'h40, 32'hdead_beef);
    read_word(ADR_SCALAR, rdata);
    expect_equal(rdata, model_scalar, "scalar after ignored writes");
    sweep_vrf();

    // Unmapped reads from each hole in the map
    for (int unsigned k = 0; k < NR_UNMAPPED; k++) begin
      rnd = $random(seed);
      case (k % 3)
        0:       adr = {2'b11, rnd[5:0]};
        1:       adr = {2'b01, rnd[5:0]};
        default: adr = {2'b00, rnd[5:0] | 6'h04};
      endcase
      read_word(adr, rdata);
      expect_equal(rdata, '0, $sformatf("unmapped word 0x%02h", adr));
    end

    $display("Checks: %0d, errors: %0d, bus operations: %0d", checks, errors, bus_ops);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_vec_unit

`default_nettype wire

/* sim.f */
+incdir+include
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_lane.sv
source/vec_reduction.sv
source/vec_unit.sv
verif/tb_vec_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --top-module tb_vec_unit -f sim.f -o Vtb_vec_unit

# Keep the log even when the simulator exits with an error
if ./obj_dir/Vtb_vec_unit > "$LOG" 2>&1; then
  status=0
else
  status=$?
fi
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
